//--- design/evr_settings.svh
// shared evr constants; include wherever comma, event code or stretch values are needed
`ifndef EVR_SETTINGS_SVH
`define EVR_SETTINGS_SVH

////////////////////
// comma alignment

// good K28.5 commas needed since the last error word
`define EVR_COMMAS_NEEDED 60

// K28.5 byte value on byte 0
`define EVR_COMMA_CHAR 8'hBC

////////////////////
// event codes

`define EVR_HB_CODE  8'd122 // heartbeat
`define EVR_PPS_CODE 8'd125 // pulse per second

////////////////////
// marker stretching

// stretch lengths in evrClk cycles
`define EVR_HB_STRETCH  40 // short for simulation, real hardware uses a third of a second
`define EVR_PPS_STRETCH 6

// channel 0 heartbeat, channel 1 pps
`define EVR_MARKER_COUNT 2

`endif

//--- design/evrPkg.sv
// common evr receive types, referenced by scoped name from the design files
`include "evr_settings.svh"

package evrPkg;

    ////////////////////
    // transceiver word

    // two decoded bytes, byte 0 in the low half
    typedef logic [15:0] rxChars_t;

    // one K flag per byte, also used for the per-byte error flags
    typedef logic [1:0] charIsK_t;

    ////////////////////
    // event path

    typedef logic [7:0] evrCode_t; // one event code

    // one bit per marker channel
    typedef logic [`EVR_MARKER_COUNT-1:0] markerVec_t;

endpackage

//--- design/rxWordIf.sv
// one decoded receive word with its flags, passed from the top level to the aligner
`timescale 1ns/1ps

interface rxWordIf;

    // a new word every evrClk cycle, no handshake
    evrPkg::rxChars_t data;       // decoded bytes
    evrPkg::charIsK_t isK;        // K character per byte
    evrPkg::charIsK_t notInTable; // 8b10b code violation per byte
    evrPkg::charIsK_t dispErr;    // running disparity error per byte

    // transceiver side
    modport source (
        output data,
        output isK,
        output notInTable,
        output dispErr
    );

    // aligner side
    modport sink (
        input data,
        input isK,
        input notInTable,
        input dispErr
    );

endinterface

//--- design/commaAligner.sv
// detects comma alignment, qualifies receive words and makes the bit-slip pulse
`timescale 1ns/1ps
`include "evr_settings.svh"

module commaAligner (
    input  logic             evrClk,
    input  logic             rst_i,
    rxWordIf.sink            rxWord,
    input  logic             slideRequest_i, // asynchronous level
    output evrPkg::rxChars_t evrChars_o,
    output evrPkg::charIsK_t evrCharIsK_o,
    output logic             aligned_o,
    output logic             bitSlide_o
);

    // counter runs from COMMA_RELOAD down past zero
    // top bit set means enough commas were seen
    localparam int COMMA_RELOAD = `EVR_COMMAS_NEEDED - 1;
    localparam int COMMA_WIDTH  = $clog2(COMMA_RELOAD + 1) + 1;

    logic [COMMA_WIDTH-1:0] commaCount;
    logic                   rxDataErr;
    logic                   goodComma;

    logic slideMeta;  // first sync stage
    logic slideSync;  // second sync stage
    logic slideLast;  // edge detect history

    ////////////////////
    // alignment

    assign aligned_o = commaCount[COMMA_WIDTH-1];

    // K is only legal on byte 0
    assign rxDataErr = (rxWord.notInTable != '0)
                    || (rxWord.dispErr != '0)
                    || rxWord.isK[1];

    assign goodComma = !rxDataErr && rxWord.isK[0]
                    && (rxWord.data[7:0] == `EVR_COMMA_CHAR);

    always_ff @(posedge evrClk) begin
        if (rst_i) begin
            commaCount <= COMMA_WIDTH'(COMMA_RELOAD);
        end else if (rxDataErr) begin
            commaCount <= COMMA_WIDTH'(COMMA_RELOAD); // start over
        end else if (!aligned_o && goodComma) begin
            commaCount <= commaCount - 1'b1; // commas need not be adjacent
        end
    end

    ////////////////////
    // word qualification

    // zero unless aligned and clean, so nothing downstream sees garbage
    always_ff @(posedge evrClk) begin
        if (aligned_o && !rxDataErr) begin
            evrChars_o   <= rxWord.data;
            evrCharIsK_o <= rxWord.isK;
        end else begin
            evrChars_o   <= '0;
            evrCharIsK_o <= '0;
        end
    end

    ////////////////////
    // bit slip

    // two flops to settle the async request, then rising edge detect
    always_ff @(posedge evrClk) begin
        if (rst_i) begin
            slideMeta  <= 1'b0;
            slideSync  <= 1'b0;
            slideLast  <= 1'b0;
            bitSlide_o <= 1'b0;
        end else begin
            slideMeta  <= slideRequest_i;
            slideSync  <= slideMeta;
            slideLast  <= slideSync;
            bitSlide_o <= slideSync && !slideLast; // one cycle per request edge
        end
    end

endmodule

//--- design/eventCodeExtractor.sv
// picks event codes out of the qualified character stream with a valid strobe
`timescale 1ns/1ps

module eventCodeExtractor (
    input  logic             evrClk,
    input  logic             rst_i,
    input  evrPkg::rxChars_t evrChars_i,
    input  evrPkg::charIsK_t evrCharIsK_i,
    output evrPkg::evrCode_t evrCode_o,
    output logic             evrCodeValid_o
);

    logic goodCode;

    // byte 0 carries the event, byte 1 belongs to the distributed bus
    // zero is the null event, K bytes are commas
    assign goodCode = (evrChars_i[7:0] != '0) && !evrCharIsK_i[0];

    always_ff @(posedge evrClk) begin
        if (rst_i) begin
            evrCode_o      <= '0;
            evrCodeValid_o <= 1'b0;
        end else begin
            evrCode_o      <= goodCode ? evrChars_i[7:0] : '0; // zero when not valid
            evrCodeValid_o <= goodCode;
        end
    end

endmodule

//--- design/markerStretcher.sv
// holds one marker high for a fixed time after a matching event code
`timescale 1ns/1ps

module markerStretcher #(
    parameter evrPkg::evrCode_t TRIGGER_CODE = 8'd0, // code that fires this channel
    parameter int unsigned      STRETCH      = 1     // marker length in cycles
) (
    input  logic             evrClk,
    input  logic             rst_i,
    input  evrPkg::evrCode_t evrCode_i,
    input  logic             evrCodeValid_i,
    output logic             marker_o,
    output logic             hit_o
);

    localparam int CNT_WIDTH = $clog2(STRETCH + 1);

    logic [CNT_WIDTH-1:0] holdCount; // cycles of marker left
    logic                 match;

    assign match    = evrCodeValid_i && (evrCode_i == TRIGGER_CODE);
    assign marker_o = (holdCount != '0);

    ////////////////////
    // stretch counter

    // reload on every match, so a repeat restarts the window
    always_ff @(posedge evrClk) begin
        if (rst_i) begin
            holdCount <= '0;
        end else if (match) begin
            holdCount <= CNT_WIDTH'(STRETCH);
        end else if (marker_o) begin
            holdCount <= holdCount - 1'b1;
        end
    end

    // hit lines up with the rising marker
    // a retrigger while already high gives no second hit
    always_ff @(posedge evrClk) begin
        if (rst_i) begin
            hit_o <= 1'b0;
        end else begin
            hit_o <= match && !marker_o;
        end
    end

endmodule

//--- design/markerCollector.sv
// registers the marker bus and keeps a sticky seen flag per channel
`timescale 1ns/1ps

module markerCollector (
    input  logic               evrClk,
    input  logic               rst_i,
    input  evrPkg::markerVec_t marker_i,
    input  evrPkg::markerVec_t hit_i,
    input  logic               clearSeen_i, // one-cycle strobe
    output evrPkg::markerVec_t marker_o,
    output evrPkg::markerVec_t seen_o
);

    ////////////////////
    // marker output

    always_ff @(posedge evrClk) begin
        if (rst_i) begin
            marker_o <= '0;
        end else begin
            marker_o <= marker_i; // one stage, keeps seen aligned with marker
        end
    end

    ////////////////////
    // seen flags

    // set beats clear when both land in the same cycle
    always_ff @(posedge evrClk) begin
        if (rst_i) begin
            seen_o <= '0;
        end else begin
            seen_o <= hit_i | (clearSeen_i ? '0 : seen_o);
        end
    end

endmodule

//--- design/evrReceiver.sv
// top level of the evr receive event logic, fed by decoded transceiver words
`timescale 1ns/1ps
`include "evr_settings.svh"

module evrReceiver (
    input  logic               evrClk,
    input  logic               rst_i,

    // decoded transceiver word
    input  evrPkg::rxChars_t   rxData_i,
    input  evrPkg::charIsK_t   rxIsK_i,
    input  evrPkg::charIsK_t   rxNotInTable_i,
    input  evrPkg::charIsK_t   rxDispErr_i,

    // control
    input  logic               slideRequest_i, // async level
    input  logic               clearSeen_i,    // strobe

    output logic               aligned_o,
    output logic               bitSlide_o,
    output evrPkg::evrCode_t   evrCode_o,
    output logic               evrCodeValid_o,
    output evrPkg::markerVec_t marker_o,
    output evrPkg::markerVec_t seen_o
);

    evrPkg::rxChars_t   evrChars;     // qualified characters
    evrPkg::charIsK_t   evrCharIsK;
    evrPkg::markerVec_t markerRaw;    // stretcher outputs, before the collector
    evrPkg::markerVec_t markerHit;

    ////////////////////
    // receive word

    // the ports play the transceiver side of the interface
    rxWordIf rxWord ();
    assign rxWord.data       = rxData_i;
    assign rxWord.isK        = rxIsK_i;
    assign rxWord.notInTable = rxNotInTable_i;
    assign rxWord.dispErr    = rxDispErr_i;

    commaAligner u_aligner (
        .evrClk         (evrClk),
        .rst_i          (rst_i),
        .rxWord         (rxWord.sink),
        .slideRequest_i (slideRequest_i),
        .evrChars_o     (evrChars),
        .evrCharIsK_o   (evrCharIsK),
        .aligned_o      (aligned_o),
        .bitSlide_o     (bitSlide_o)
    );

    eventCodeExtractor u_extractor (
        .evrClk         (evrClk),
        .rst_i          (rst_i),
        .evrChars_i     (evrChars),
        .evrCharIsK_i   (evrCharIsK),
        .evrCode_o      (evrCode_o),
        .evrCodeValid_o (evrCodeValid_o)
    );

    ////////////////////
    // markers

    // channel 0 heartbeat, everything above it pps
    for (genvar ch = 0; ch < `EVR_MARKER_COUNT; ch++) begin : gMarker
        localparam evrPkg::evrCode_t CH_CODE    = (ch == 0) ? `EVR_HB_CODE : `EVR_PPS_CODE;
        localparam int unsigned      CH_STRETCH = (ch == 0) ? `EVR_HB_STRETCH : `EVR_PPS_STRETCH;

        markerStretcher #(
            .TRIGGER_CODE (CH_CODE),
            .STRETCH      (CH_STRETCH)
        ) u_stretch (
            .evrClk         (evrClk),
            .rst_i          (rst_i),
            .evrCode_i      (evrCode_o),
            .evrCodeValid_i (evrCodeValid_o),
            .marker_o       (markerRaw[ch]),
            .hit_o          (markerHit[ch])
        );
    end

    markerCollector u_collector (
        .evrClk      (evrClk),
        .rst_i       (rst_i),
        .marker_i    (markerRaw),
        .hit_i       (markerHit),
        .clearSeen_i (clearSeen_i),
        .marker_o    (marker_o),
        .seen_o      (seen_o)
    );

endmodule

//--- tests/evrReceiver_properties.sv
// port-level timing checks of the evr receiver, attached to the top level with bind
`timescale 1ns/1ps
`include "evr_settings.svh"

module evrReceiver_properties (
    input logic               evrClk,
    input logic               rst_i,
    input evrPkg::rxChars_t   rxData_i,
    input evrPkg::charIsK_t   rxIsK_i,
    input evrPkg::charIsK_t   rxNotInTable_i,
    input evrPkg::charIsK_t   rxDispErr_i,
    input logic               slideRequest_i,
    input logic               clearSeen_i,
    input logic               aligned_o,
    input logic               bitSlide_o,
    input evrPkg::evrCode_t   evrCode_o,
    input logic               evrCodeValid_o,
    input evrPkg::markerVec_t marker_o,
    input evrPkg::markerVec_t seen_o
);

    int   failCount = 0; // polled by the testbench
    int   commaSeen;     // good commas since the last error word, saturates
    logic wordErr;
    logic codeExpected;  // this word must show up as a code two cycles on

    assign wordErr = (rxNotInTable_i != '0) || (rxDispErr_i != '0) || rxIsK_i[1];
    assign codeExpected = aligned_o && !wordErr && !rxIsK_i[0] && (rxData_i[7:0] != 8'h00);

    always_ff @(posedge evrClk) begin
        if (rst_i || wordErr) begin
            commaSeen <= 0;
        end else if (rxIsK_i[0] && (rxData_i[7:0] == `EVR_COMMA_CHAR)
                     && (commaSeen < `EVR_COMMAS_NEEDED)) begin
            commaSeen <= commaSeen + 1;
        end
    end

    ////////////////////
    // alignment and codes

    alignedAfterCommas: assert property (@(posedge evrClk) disable iff (rst_i)
        aligned_o == (commaSeen == `EVR_COMMAS_NEEDED))
        else begin
            failCount++;
            $error("MISMATCH %0t aligned_o disagrees with the comma count", $time);
        end

    codeTwoLater: assert property (@(posedge evrClk) disable iff (rst_i)
        {evrCodeValid_o, evrCode_o}
            == ($past(codeExpected, 2) ? {1'b1, $past(rxData_i[7:0], 2)} : 9'h000))
        else begin
            failCount++;
            $error("MISMATCH %0t event code or valid wrong for the word 2 cycles back", $time);
        end

    ////////////////////
    // markers and seen flags

    for (genvar n = 0; n < `EVR_MARKER_COUNT; n++) begin : gChannel
        localparam evrPkg::evrCode_t CODE = (n == 0) ? `EVR_HB_CODE : `EVR_PPS_CODE;
        localparam int STRETCH = (n == 0) ? `EVR_HB_STRETCH : `EVR_PPS_STRETCH;

        int   codeAge;   // cycles since the latest matching code, STRETCH + 2 when idle
        logic stillHigh; // older window still open when the latest code came in

        always_ff @(posedge evrClk) begin
            if (rst_i) begin
                codeAge   <= STRETCH + 2;
                stillHigh <= 1'b0;
            end else if (evrCodeValid_o && (evrCode_o == CODE)) begin
                codeAge   <= 1; // later code restarts the window
                stillHigh <= (codeAge <= STRETCH);
            end else if (codeAge <= STRETCH + 1) begin
                codeAge <= codeAge + 1;
            end
        end

        // a retrigger keeps the marker up across the cycle before the new window
        markerWindow: assert property (@(posedge evrClk) disable iff (rst_i)
            marker_o[n] == ((codeAge == 1) ? stillHigh
                                           : ((codeAge >= 2) && (codeAge <= STRETCH + 1))))
            else begin
                failCount++;
                $error("MISMATCH %0t marker %0d outside its stretch window", $time, n);
            end

        // set with the rising marker, held until the cycle after a clear
        seenSticky: assert property (@(posedge evrClk) disable iff (rst_i)
            seen_o[n] == ($rose(marker_o[n]) || ($past(seen_o[n]) && !$past(clearSeen_i))))
            else begin
                failCount++;
                $error("MISMATCH %0t seen flag %0d set or cleared at the wrong time", $time, n);
            end
    end

    ////////////////////
    // bit slip

    slideOnce: assert property (@(posedge evrClk) disable iff (rst_i)
        bitSlide_o == ($past(slideRequest_i, 3) && !$past(slideRequest_i, 4)))
        else begin
            failCount++;
            $error("MISMATCH %0t bitSlide_o not 3 cycles after a request edge", $time);
        end

endmodule

bind evrReceiver evrReceiver_properties i_props (.*);

//--- tests/evrReceiverTb.sv
// testbench for the evr receiver top level, drives the receive stream while bound assertions check
`timescale 1ns/1ps
`include "evr_settings.svh"

module evrReceiverTb;

    localparam int PHASE1_CYCLES  = 42;                       // commas around one error word
    localparam int PHASE2_CYCLES  = 2 * `EVR_COMMAS_NEEDED;   // commas and fillers until locked
    localparam int PHASE3_CYCLES  = 40 + 2 * `EVR_HB_STRETCH; // codes, then heartbeat runs out
    localparam int PHASE45_CYCLES = 10 + 3 * 24;              // clear strobes, slide edges
    localparam int CYCLE_LIMIT    = 5 + PHASE1_CYCLES + PHASE2_CYCLES + PHASE3_CYCLES
                                  + PHASE45_CYCLES + 200;

    logic               evrClk = 1'b0;
    logic               rst;
    evrPkg::rxChars_t   rxData;
    evrPkg::charIsK_t   rxIsK;
    evrPkg::charIsK_t   rxNotInTable;
    evrPkg::charIsK_t   rxDispErr;
    logic               slideRequest;
    logic               clearSeen;
    logic               aligned;
    logic               bitSlide;
    evrPkg::evrCode_t   evrCode;
    logic               evrCodeValid;
    evrPkg::markerVec_t marker;
    evrPkg::markerVec_t seen;

    logic [31:0] lfsrState  = 32'h55ef_e3b7;
    int          cycleCount = 0;

    always #50 evrClk = ~evrClk; // 100 ns period

    evrReceiver i_dut (
        .evrClk         (evrClk),
        .rst_i          (rst),
        .rxData_i       (rxData),
        .rxIsK_i        (rxIsK),
        .rxNotInTable_i (rxNotInTable),
        .rxDispErr_i    (rxDispErr),
        .slideRequest_i (slideRequest),
        .clearSeen_i    (clearSeen),
        .aligned_o      (aligned),
        .bitSlide_o     (bitSlide),
        .evrCode_o      (evrCode),
        .evrCodeValid_o (evrCodeValid),
        .marker_o       (marker),
        .seen_o         (seen)
    );

    ////////////////////
    // stimulus helpers

    // x^32 + x^22 + x^2 + x + 1, new bit enters at the bottom
    function automatic logic [31:0] lfsrNext(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic takeBits(input int count, output logic [15:0] bits);
        bits = '0;
        for (int i = 0; i < count; i++) begin
            lfsrState = lfsrNext(lfsrState); // one step per bit
            bits = {bits[14:0], lfsrState[0]};
        end
    endtask

    // one word per cycle, applied on the falling edge
    task automatic sendWord(input evrPkg::rxChars_t data, input evrPkg::charIsK_t isK,
                            input evrPkg::charIsK_t notInTable, input evrPkg::charIsK_t dispErr);
        @(negedge evrClk);
        rxData       = data;
        rxIsK        = isK;
        rxNotInTable = notInTable;
        rxDispErr    = dispErr;
        clearSeen    = 1'b0; // strobe lasts one word
    endtask

    task automatic sendFiller();
        logic [15:0] bits;
        takeBits(16, bits);
        sendWord(bits, 2'b00, 2'b00, 2'b00); // never K
    endtask

    // K28.5 on byte 0, random byte 1
    task automatic sendComma();
        logic [15:0] bits;
        takeBits(8, bits);
        sendWord({bits[7:0], `EVR_COMMA_CHAR}, 2'b01, 2'b00, 2'b00);
    endtask

    // a filler one time in four, so commas are not always adjacent
    task automatic sendCommaOrFiller();
        logic [15:0] pick;
        takeBits(2, pick);
        if (pick[1:0] == 2'b11) begin
            sendFiller();
        end else begin
            sendComma();
        end
    endtask

    ////////////////////
    // failure and timeout watch

    // assertions fire on the rising edge, seen here half a cycle later
    always @(negedge evrClk) begin
        if (i_dut.i_props.failCount != 0) begin
            $display("** FAIL **");
            $fatal(1, "a timing property of the receiver failed");
        end
    end

    always @(posedge evrClk) begin
        cycleCount++;
        if (cycleCount > CYCLE_LIMIT) begin
            $display("** FAIL **");
            $fatal(1, "timeout, stimulus still running after %0d cycles", cycleCount);
        end
    end

    ////////////////////
    // phases

    initial begin
        logic [15:0] hold;
        rst          = 1'b1;
        rxData       = '0;
        rxIsK        = '0;
        rxNotInTable = '0;
        rxDispErr    = '0;
        slideRequest = 1'b0;
        clearSeen    = 1'b0;
        repeat (5) @(posedge evrClk);
        @(negedge evrClk);
        rst = 1'b0;

        // partial comma run broken by a code violation
        repeat (20) sendCommaOrFiller();
        sendWord({8'h00, `EVR_COMMA_CHAR}, 2'b01, 2'b10, 2'b00);
        repeat (20) sendCommaOrFiller();

        while (!aligned) begin
            sendCommaOrFiller(); // until the receiver locks
        end

        // random traffic with both marker codes
        repeat (8) sendFiller();
        sendWord({8'h00, `EVR_HB_CODE}, 2'b00, 2'b00, 2'b00);
        repeat (4) sendFiller();
        sendWord({8'h00, `EVR_PPS_CODE}, 2'b00, 2'b00, 2'b00);
        repeat (3) sendFiller();
        sendWord({8'h00, `EVR_PPS_CODE}, 2'b00, 2'b00, 2'b00); // inside the pps window
        sendWord(16'h5a00, 2'b00, 2'b00, 2'b00);               // null event
        sendComma();                                           // K byte while locked
        repeat (`EVR_HB_STRETCH + 4) sendFiller();
        sendWord({8'h00, `EVR_PPS_CODE}, 2'b00, 2'b00, 2'b01); // disparity error drops lock
        repeat (4) sendFiller();

        repeat (2) begin
            sendFiller();
            clearSeen = 1'b1;
            repeat (3) sendFiller();
        end

        // slide request edges, random hold times
        repeat (3) begin
            takeBits(3, hold);
            sendFiller();
            slideRequest = 1'b1;
            repeat (hold + 2) sendFiller();
            slideRequest = 1'b0;
            repeat (hold + 4) sendFiller();
        end
        repeat (4) sendFiller();

        if (i_dut.i_props.failCount == 0) begin
            $display("** PASS **");
            $finish;
        end else begin
            $display("** FAIL **");
            $fatal(1, "a timing property of the receiver failed");
        end
    end

endmodule

//--- tb.f
+incdir+design
design/evrPkg.sv
design/rxWordIf.sv
design/commaAligner.sv
design/eventCodeExtractor.sv
design/markerStretcher.sv
design/markerCollector.sv
design/evrReceiver.sv
tests/evrReceiver_properties.sv
tests/evrReceiverTb.sv

//--- Makefile
# Verilator flow for the evr receiver testbench
TOP := evrReceiverTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f tb.f --top-module $(TOP)

# the run log decides pass or fail
sim:
	verilator --binary --timing --assert -j 0 -f tb.f --top-module $(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee sim.log
	grep -q '^\*\* PASS \*\*$$' sim.log

clean:
	rm -rf obj_dir sim.log
